/* src/axi2fifo_cfg.svh */
`ifndef AXI2FIFO_CFG_SVH
`define AXI2FIFO_CFG_SVH

// AXI4 bus geometry
`define AXI_ADDR_WIDTH  7
`define AXI_DATA_WIDTH  128
`define AXI_ID_WIDTH    16
`define AXI_LEN_WIDTH   8

// Image size register fields
`define IMG_WIDTH_BITS  12
`define IMG_HEIGHT_BITS 11

// DRAM read request address
`define DRAM_ADDR_WIDTH 39

// Write address map
`define REG_FIFO_DATA     7'h00
`define REG_FLUSH         7'h10
`define REG_IMAGE_SIZE    7'h20
`define REG_SET_NEW_IMAGE 7'h50
`define REG_DEASSERT_IRQ  7'h60

// Read address map
`define REG_DRAM_REQ      7'h00
`define REG_RESOLUTION    7'h10

`endif

/* src/axi2fifo_pkg.sv */
`default_nettype none

package axi2fifo_pkg;

    // Write command decoded from awaddr
    typedef enum logic [2:0] {
        CMD_FIFO_DATA,
        CMD_FLUSH,
        CMD_IMAGE_SIZE,
        CMD_SET_NEW_IMAGE,
        CMD_DEASSERT_IRQ,
        CMD_BAD_ADDR
    } wr_cmd_t;

    // Read source decoded from araddr
    typedef enum logic [1:0] {
        SRC_DRAM_REQ,
        SRC_RESOLUTION,
        SRC_BAD_ADDR
    } rd_cmd_t;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axi_resp_t;

    typedef enum logic [1:0] {ST_WR_IDLE, ST_WR_DATA, ST_WR_RESP} wr_state_t;

    typedef enum logic {ST_RD_IDLE, ST_RD_BEAT} rd_state_t;

endpackage

`default_nettype wire

/* src/wr_addr_decode.sv */
`default_nettype none

`include "axi2fifo_cfg.svh"

module wr_addr_decode (
    input  wire                         s_axi_aclk,
    input  wire                         s_axi_aresetn,
    input  wire [`AXI_ADDR_WIDTH-1:0]   s_axi_awaddr,
    input  wire [`AXI_ID_WIDTH-1:0]     s_axi_awid,
    input  wire                         s_axi_awvalid,
    output logic                        s_axi_awready,
    input  wire                         s_axi_bready,
    output logic                        s_axi_bvalid,
    output axi2fifo_pkg::axi_resp_t     s_axi_bresp,
    output logic [`AXI_ID_WIDTH-1:0]    s_axi_bid,
    input  wire                         data_done,
    output logic                        cmd_start,
    output axi2fifo_pkg::wr_cmd_t       cmd
);

    import axi2fifo_pkg::*;

    wr_state_t state;
    logic      aw_fire;

    // Map a write offset onto its command
    function automatic wr_cmd_t decode_wr(input logic [`AXI_ADDR_WIDTH-1:0] addr);
        case (addr)
            `REG_FIFO_DATA:     decode_wr = CMD_FIFO_DATA;
            `REG_FLUSH:         decode_wr = CMD_FLUSH;
            `REG_IMAGE_SIZE:    decode_wr = CMD_IMAGE_SIZE;
            `REG_SET_NEW_IMAGE: decode_wr = CMD_SET_NEW_IMAGE;
            `REG_DEASSERT_IRQ:  decode_wr = CMD_DEASSERT_IRQ;
            default:            decode_wr = CMD_BAD_ADDR;
        endcase
    endfunction

    assign s_axi_awready = (state == ST_WR_IDLE);
    assign aw_fire       = s_axi_awvalid && s_axi_awready;

    ////////////////////////////////////////
    // Write address FSM
    ////////////////////////////////////////
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            state        <= ST_WR_IDLE;
            cmd_start    <= 1'b0;
            s_axi_bvalid <= 1'b0;
        end else begin
            cmd_start <= 1'b0;
            case (state)
                ST_WR_IDLE: begin
                    if (aw_fire) begin
                        cmd_start <= 1'b1;
                        state     <= ST_WR_DATA;
                    end
                end
                ST_WR_DATA: begin
                    // Response goes out once the last beat has been taken
                    if (data_done) begin
                        s_axi_bvalid <= 1'b1;
                        state        <= ST_WR_RESP;
                    end
                end
                ST_WR_RESP: begin
                    if (s_axi_bready) begin
                        s_axi_bvalid <= 1'b0;
                        state        <= ST_WR_IDLE;
                    end
                end
                default: state <= ST_WR_IDLE;
            endcase
        end
    end

    // Command and id captured with the address
    always_ff @(posedge s_axi_aclk) begin
        if (aw_fire) begin
            cmd       <= decode_wr(s_axi_awaddr);
            s_axi_bid <= s_axi_awid;
        end
        if (state == ST_WR_DATA && data_done) begin
            s_axi_bresp <= (cmd == CMD_BAD_ADDR) ? RESP_SLVERR : RESP_OKAY;
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////
    a_bvalid_hold: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid);

    // A command only follows an address accepted in idle
    a_cmd_from_idle: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        cmd_start |-> $past(state == ST_WR_IDLE));

endmodule

`default_nettype wire

/* src/wr_data_exec.sv */
`default_nettype none

`include "axi2fifo_cfg.svh"

module wr_data_exec (
    input  wire                          s_axi_aclk,
    input  wire                          s_axi_aresetn,
    input  wire                          cmd_start,
    input  wire axi2fifo_pkg::wr_cmd_t   cmd,
    input  wire [`AXI_DATA_WIDTH-1:0]    s_axi_wdata,
    input  wire                          s_axi_wvalid,
    input  wire                          s_axi_wlast,
    output logic                         s_axi_wready,
    output logic                         data_done,
    input  wire                          image_sender_full,
    output logic                         image_sender_write,
    output logic                         image_sender_flush,
    output logic [`AXI_DATA_WIDTH-1:0]   image_sender_fifo_din,
    output logic [`IMG_WIDTH_BITS-1:0]   image_width,
    output logic [`IMG_HEIGHT_BITS-1:0]  image_height,
    output logic                         set_new_image,
    input  wire                          dram_read_en,
    output logic                         irq_signal
);

    import axi2fifo_pkg::*;

    logic    active;
    wr_cmd_t active_cmd;
    logic    beat;
    logic    fifo_cmd;

    ////////////////////////////////////////
    // W channel handshake
    ////////////////////////////////////////
    assign fifo_cmd = (active_cmd == CMD_FIFO_DATA);

    // Only pixel data is throttled by the FIFO
    assign s_axi_wready = active && !(fifo_cmd && image_sender_full);
    assign beat         = s_axi_wvalid && s_axi_wready;
    assign data_done    = beat && s_axi_wlast;

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            active <= 1'b0;
        end else if (cmd_start) begin
            active <= 1'b1;
        end else if (data_done) begin
            active <= 1'b0;
        end
    end

    always_ff @(posedge s_axi_aclk) begin
        if (cmd_start) begin
            active_cmd <= cmd;
        end
    end

    ////////////////////////////////////////
    // Command effects
    ////////////////////////////////////////
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            image_sender_write <= 1'b0;
            image_sender_flush <= 1'b0;
            set_new_image      <= 1'b0;
        end else begin
            image_sender_write <= beat && fifo_cmd;
            image_sender_flush <= beat && (active_cmd == CMD_FLUSH) && s_axi_wdata[0];
            set_new_image      <= data_done && (active_cmd == CMD_SET_NEW_IMAGE);
        end
    end

    // Pixel word follows its write strobe
    always_ff @(posedge s_axi_aclk) begin
        if (beat && fifo_cmd) begin
            image_sender_fifo_din <= s_axi_wdata;
        end
    end

    // Width from the upper word, height from the lower one
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            image_width  <= '0;
            image_height <= '0;
        end else if (beat && (active_cmd == CMD_IMAGE_SIZE)) begin
            image_width  <= s_axi_wdata[32 +: `IMG_WIDTH_BITS];
            image_height <= s_axi_wdata[0 +: `IMG_HEIGHT_BITS];
        end
    end

    // A new DRAM request takes priority over the host's clear
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            irq_signal <= 1'b0;
        end else if (dram_read_en) begin
            irq_signal <= 1'b1;
        end else if (data_done && (active_cmd == CMD_DEASSERT_IRQ)) begin
            irq_signal <= 1'b0;
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////
    a_no_write_when_full: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        active && fifo_cmd && s_axi_wvalid && image_sender_full |=> !image_sender_write);

endmodule

`default_nettype wire

/* src/rd_engine.sv */
`default_nettype none

`include "axi2fifo_cfg.svh"

module rd_engine (
    input  wire                          s_axi_aclk,
    input  wire                          s_axi_aresetn,
    input  wire [`AXI_ADDR_WIDTH-1:0]    s_axi_araddr,
    input  wire [`AXI_ID_WIDTH-1:0]      s_axi_arid,
    input  wire [`AXI_LEN_WIDTH-1:0]     s_axi_arlen,
    input  wire                          s_axi_arvalid,
    output logic                         s_axi_arready,
    input  wire                          s_axi_rready,
    output logic [`AXI_DATA_WIDTH-1:0]   s_axi_rdata,
    output axi2fifo_pkg::axi_resp_t      s_axi_rresp,
    output logic                         s_axi_rvalid,
    output logic                         s_axi_rlast,
    output logic [`AXI_ID_WIDTH-1:0]     s_axi_rid,
    input  wire [`DRAM_ADDR_WIDTH-1:0]   dram_read_addr,
    input  wire [`AXI_LEN_WIDTH-1:0]     dram_read_len,
    input  wire [`IMG_WIDTH_BITS-1:0]    image_width,
    input  wire [`IMG_HEIGHT_BITS-1:0]   image_height
);

    import axi2fifo_pkg::*;

    rd_state_t                  state;
    rd_cmd_t                    src;
    rd_cmd_t                    next_src;
    logic [`AXI_LEN_WIDTH-1:0]  beats_left;
    logic [`AXI_DATA_WIDTH-1:0] beat_data;
    logic                       ar_fire;
    logic                       r_fire;

    assign s_axi_arready = (state == ST_RD_IDLE);
    assign ar_fire       = s_axi_arvalid && s_axi_arready;
    assign r_fire        = s_axi_rvalid && s_axi_rready;

    ////////////////////////////////////////
    // Source decode and beat formatting
    ////////////////////////////////////////
    always_comb begin
        next_src = src;
        if (state == ST_RD_IDLE) begin
            case (s_axi_araddr)
                `REG_DRAM_REQ:   next_src = SRC_DRAM_REQ;
                `REG_RESOLUTION: next_src = SRC_RESOLUTION;
                default:         next_src = SRC_BAD_ADDR;
            endcase
        end
    end

    // Sources are sampled again on every beat
    always_comb begin
        beat_data = '0;
        case (next_src)
            SRC_DRAM_REQ: begin
                beat_data[0 +: `DRAM_ADDR_WIDTH] = dram_read_addr;
                beat_data[64 +: `AXI_LEN_WIDTH]  = dram_read_len;
            end
            SRC_RESOLUTION: begin
                beat_data[32 +: `IMG_WIDTH_BITS] = image_width;
                beat_data[0 +: `IMG_HEIGHT_BITS] = image_height;
            end
            default: beat_data = '0;
        endcase
    end

    ////////////////////////////////////////
    // R channel burst
    ////////////////////////////////////////
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            state        <= ST_RD_IDLE;
            s_axi_rvalid <= 1'b0;
            s_axi_rlast  <= 1'b0;
        end else if (ar_fire) begin
            state        <= ST_RD_BEAT;
            s_axi_rvalid <= 1'b1;
            // Bad address always answers with a single beat
            s_axi_rlast  <= (next_src == SRC_BAD_ADDR) || (s_axi_arlen == '0);
        end else if (r_fire) begin
            if (s_axi_rlast) begin
                state        <= ST_RD_IDLE;
                s_axi_rvalid <= 1'b0;
                s_axi_rlast  <= 1'b0;
            end else begin
                s_axi_rlast <= (beats_left == `AXI_LEN_WIDTH'(1));
            end
        end
    end

    always_ff @(posedge s_axi_aclk) begin
        if (ar_fire) begin
            src         <= next_src;
            beats_left  <= s_axi_arlen;
            s_axi_rid   <= s_axi_arid;
            s_axi_rresp <= (next_src == SRC_BAD_ADDR) ? RESP_SLVERR : RESP_OKAY;
            s_axi_rdata <= beat_data;
        end else if (r_fire && !s_axi_rlast) begin
            beats_left  <= beats_left - `AXI_LEN_WIDTH'(1);
            s_axi_rdata <= beat_data;
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////
    a_rdata_stable: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        s_axi_rvalid && !s_axi_rready |=> $stable(s_axi_rdata));

    a_rlast_valid: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        s_axi_rlast |-> s_axi_rvalid);

endmodule

`default_nettype wire

/* src/axi2fifo_top.sv */
`default_nettype none

`include "axi2fifo_cfg.svh"

module axi2fifo_top (
    input  wire                          s_axi_aclk,
    input  wire                          s_axi_aresetn,
    // Write address
    input  wire [`AXI_ADDR_WIDTH-1:0]    s_axi_awaddr,
    input  wire [`AXI_ID_WIDTH-1:0]      s_axi_awid,
    input  wire                          s_axi_awvalid,
    output logic                         s_axi_awready,
    // Write data
    input  wire [`AXI_DATA_WIDTH-1:0]    s_axi_wdata,
    input  wire                          s_axi_wvalid,
    input  wire                          s_axi_wlast,
    output logic                         s_axi_wready,
    // Write response
    input  wire                          s_axi_bready,
    output logic                         s_axi_bvalid,
    output axi2fifo_pkg::axi_resp_t      s_axi_bresp,
    output logic [`AXI_ID_WIDTH-1:0]     s_axi_bid,
    // Read address
    input  wire [`AXI_ADDR_WIDTH-1:0]    s_axi_araddr,
    input  wire [`AXI_ID_WIDTH-1:0]      s_axi_arid,
    input  wire [`AXI_LEN_WIDTH-1:0]     s_axi_arlen,
    input  wire                          s_axi_arvalid,
    output logic                         s_axi_arready,
    // Read data
    input  wire                          s_axi_rready,
    output logic [`AXI_DATA_WIDTH-1:0]   s_axi_rdata,
    output axi2fifo_pkg::axi_resp_t      s_axi_rresp,
    output logic                         s_axi_rvalid,
    output logic                         s_axi_rlast,
    output logic [`AXI_ID_WIDTH-1:0]     s_axi_rid,
    // Image sender FIFO and image registers
    output logic                         image_sender_reset,
    output logic                         image_sender_flush,
    output logic                         image_sender_write,
    output logic [`AXI_DATA_WIDTH-1:0]   image_sender_fifo_din,
    output logic [`IMG_WIDTH_BITS-1:0]   image_width,
    output logic [`IMG_HEIGHT_BITS-1:0]  image_height,
    input  wire                          image_sender_full,
    // DRAM read request and host signalling
    input  wire [`DRAM_ADDR_WIDTH-1:0]   dram_read_addr,
    input  wire [`AXI_LEN_WIDTH-1:0]     dram_read_len,
    input  wire                          dram_read_en,
    output logic                         set_new_image,
    output logic                         irq_signal
);

    import axi2fifo_pkg::*;

    logic    cmd_start;
    wr_cmd_t cmd;
    logic    data_done;

    // FIFO reset is active high
    assign image_sender_reset = ~s_axi_aresetn;

    wr_addr_decode u_wr_addr_decode (
        .s_axi_aclk, .s_axi_aresetn,
        .s_axi_awaddr, .s_axi_awid, .s_axi_awvalid, .s_axi_awready,
        .s_axi_bready, .s_axi_bvalid, .s_axi_bresp, .s_axi_bid,
        .data_done, .cmd_start, .cmd
    );

    wr_data_exec u_wr_data_exec (
        .s_axi_aclk, .s_axi_aresetn, .cmd_start, .cmd,
        .s_axi_wdata, .s_axi_wvalid, .s_axi_wlast, .s_axi_wready, .data_done,
        .image_sender_full, .image_sender_write, .image_sender_flush,
        .image_sender_fifo_din, .image_width, .image_height,
        .set_new_image, .dram_read_en, .irq_signal
    );

    rd_engine u_rd_engine (
        .s_axi_aclk, .s_axi_aresetn,
        .s_axi_araddr, .s_axi_arid, .s_axi_arlen, .s_axi_arvalid, .s_axi_arready,
        .s_axi_rready, .s_axi_rdata, .s_axi_rresp, .s_axi_rvalid, .s_axi_rlast,
        .s_axi_rid, .dram_read_addr, .dram_read_len, .image_width, .image_height
    );

endmodule

`default_nettype wire

/* bench/tb_axi2fifo.sv */
`default_nettype none

`include "axi2fifo_cfg.svh"

module tb_axi2fifo;

    timeunit 1ns;
    timeprecision 100ps;

    import axi2fifo_pkg::*;

    localparam int WAIT_LIMIT = 2000;

    logic                         clk;
    logic                         rstn;
    logic [`AXI_ADDR_WIDTH-1:0]   awaddr;
    logic [`AXI_ID_WIDTH-1:0]     awid;
    logic                         awvalid;
    logic                         awready;
    logic [`AXI_DATA_WIDTH-1:0]   wdata;
    logic                         wvalid;
    logic                         wlast;
    logic                         wready;
    logic                         bready;
    logic                         bvalid;
    axi_resp_t                    bresp;
    logic [`AXI_ID_WIDTH-1:0]     bid;
    logic [`AXI_ADDR_WIDTH-1:0]   araddr;
    logic [`AXI_ID_WIDTH-1:0]     arid;
    logic [`AXI_LEN_WIDTH-1:0]    arlen;
    logic                         arvalid;
    logic                         arready;
    logic                         rready;
    logic [`AXI_DATA_WIDTH-1:0]   rdata;
    axi_resp_t                    rresp;
    logic                         rvalid;
    logic                         rlast;
    logic [`AXI_ID_WIDTH-1:0]     rid;
    logic                         fifo_reset;
    logic                         fifo_flush;
    logic                         fifo_write;
    logic [`AXI_DATA_WIDTH-1:0]   fifo_din;
    logic [`IMG_WIDTH_BITS-1:0]   width;
    logic [`IMG_HEIGHT_BITS-1:0]  height;
    logic                         fifo_full;
    logic [`DRAM_ADDR_WIDTH-1:0]  dram_addr;
    logic [`AXI_LEN_WIDTH-1:0]    dram_len;
    logic                         dram_en;
    logic                         new_image;
    logic                         irq;

    // Reference model state
    logic [`IMG_WIDTH_BITS-1:0]   exp_width;
    logic [`IMG_HEIGHT_BITS-1:0]  exp_height;
    logic                         exp_irq;
    logic [`AXI_DATA_WIDTH-1:0]   fifo_q[$];
    logic [`AXI_DATA_WIDTH-1:0]   beats_q[$];

    // Expected fields of the transaction in flight
    logic [1:0]                   exp_bresp;
    logic [`AXI_ID_WIDTH-1:0]     exp_bid;
    logic [`AXI_ADDR_WIDTH-1:0]   rd_off;
    logic [`AXI_ID_WIDTH-1:0]     exp_rid;
    int                           exp_beats;

    // Counters kept by the compare process
    int b_count;
    int r_bursts;
    int r_beat_idx;
    int fifo_writes;
    int flush_pulses;
    int new_image_pulses;
    int checks;
    int errors;
    int test_errors;

    logic                         held_valid;
    logic [`AXI_DATA_WIDTH-1:0]   held_data;
    logic                         full_random;
    logic                         rready_random;
    integer                       seed;

    axi2fifo_top i_dut (
        .s_axi_aclk(clk), .s_axi_aresetn(rstn),
        .s_axi_awaddr(awaddr), .s_axi_awid(awid), .s_axi_awvalid(awvalid),
        .s_axi_awready(awready),
        .s_axi_wdata(wdata), .s_axi_wvalid(wvalid), .s_axi_wlast(wlast),
        .s_axi_wready(wready),
        .s_axi_bready(bready), .s_axi_bvalid(bvalid), .s_axi_bresp(bresp), .s_axi_bid(bid),
        .s_axi_araddr(araddr), .s_axi_arid(arid), .s_axi_arlen(arlen),
        .s_axi_arvalid(arvalid), .s_axi_arready(arready),
        .s_axi_rready(rready), .s_axi_rdata(rdata), .s_axi_rresp(rresp),
        .s_axi_rvalid(rvalid), .s_axi_rlast(rlast), .s_axi_rid(rid),
        .image_sender_reset(fifo_reset), .image_sender_flush(fifo_flush),
        .image_sender_write(fifo_write), .image_sender_fifo_din(fifo_din),
        .image_width(width), .image_height(height), .image_sender_full(fifo_full),
        .dram_read_addr(dram_addr), .dram_read_len(dram_len), .dram_read_en(dram_en),
        .set_new_image(new_image), .irq_signal(irq)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] rand32();
        logic [31:0] r;
        r = $random(seed);
        return r;
    endfunction

    // Expected read beat as {rresp, rdata} from the register map
    function automatic logic [129:0] ref_read(input logic [`AXI_ADDR_WIDTH-1:0] off);
        logic [127:0] d;
        logic [1:0]   resp;
        d    = '0;
        resp = 2'b00;
        if (off == `REG_DRAM_REQ) begin
            d[38:0]  = dram_addr;
            d[71:64] = dram_len;
        end else if (off == `REG_RESOLUTION) begin
            d[10:0]  = exp_height;
            d[43:32] = exp_width;
        end else begin
            resp = 2'b10;
        end
        return {resp, d};
    endfunction

    task automatic check_val(input string name, input logic [129:0] got,
                             input logic [129:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("Timeout while waiting for %s", what);
    endtask

    ////////////////////////////////////////
    // Compare process
    ////////////////////////////////////////
    always @(posedge clk) begin
        logic [129:0] r;
        if (rstn) begin
            if (fifo_write) begin
                fifo_writes++;
                if (fifo_q.size() == 0) begin
                    errors++;
                    $display("FIFO write seen while no pixel word was expected");
                end else begin
                    check_val("image_sender_fifo_din", fifo_din, fifo_q.pop_front());
                end
            end
            if (fifo_flush) flush_pulses++;
            if (new_image) new_image_pulses++;
            if (bvalid && bready) begin
                check_val("bresp", bresp, exp_bresp);
                check_val("bid", bid, exp_bid);
                b_count++;
            end
            // Data must not move while the master stalls
            if (rvalid && held_valid) check_val("rdata stall", rdata, held_data);
            held_valid = rvalid && !rready;
            held_data  = rdata;
            if (rvalid && rready) begin
                r = ref_read(rd_off);
                check_val("rdata", rdata, r[127:0]);
                check_val("rresp", rresp, r[129:128]);
                check_val("rid", rid, exp_rid);
                check_val("rlast", rlast, r_beat_idx == exp_beats - 1);
                if (rlast) begin
                    r_beat_idx = 0;
                    r_bursts++;
                end else begin
                    r_beat_idx++;
                end
            end
        end
    end

    // Random back-pressure and stalls
    always @(posedge clk) begin
        logic [31:0] r;
        r = rand32();
        fifo_full <= full_random ? r[0] : 1'b0;
        bready    <= full_random ? r[2] : 1'b1;
        rready    <= rready_random ? r[1] : 1'b1;
    end

    ////////////////////////////////////////
    // Bus tasks
    ////////////////////////////////////////
    task automatic write_burst(input logic [`AXI_ADDR_WIDTH-1:0] addr);
        int cnt;
        int n;
        int last_b;
        logic [31:0] r;
        r         = rand32();
        last_b    = b_count;
        n         = beats_q.size();
        exp_bid   = r[15:0];
        exp_bresp = (addr == `REG_FIFO_DATA || addr == `REG_FLUSH ||
                     addr == `REG_IMAGE_SIZE || addr == `REG_SET_NEW_IMAGE ||
                     addr == `REG_DEASSERT_IRQ) ? 2'b00 : 2'b10;
        @(posedge clk);
        awaddr  <= addr;
        awid    <= r[15:0];
        awvalid <= 1'b1;
        cnt = 0;
        do begin
            @(posedge clk);
            cnt++;
        end while (!awready && cnt < WAIT_LIMIT);
        if (cnt >= WAIT_LIMIT) report_timeout("awready");
        awvalid <= 1'b0;
        for (int i = 0; i < n; i++) begin
            wdata  <= beats_q[i];
            wlast  <= (i == n - 1);
            wvalid <= 1'b1;
            cnt = 0;
            do begin
                @(posedge clk);
                cnt++;
            end while (!wready && cnt < WAIT_LIMIT);
            if (cnt >= WAIT_LIMIT) report_timeout("wready");
        end
        wvalid <= 1'b0;
        wlast  <= 1'b0;
        beats_q.delete();
        cnt = 0;
        while (b_count == last_b && cnt < WAIT_LIMIT) begin
            @(posedge clk);
            cnt++;
        end
        if (cnt >= WAIT_LIMIT) report_timeout("the write response");
    endtask

    task automatic read_burst(input logic [`AXI_ADDR_WIDTH-1:0] addr,
                              input logic [`AXI_LEN_WIDTH-1:0] len);
        int cnt;
        int last_r;
        logic [31:0] r;
        logic [129:0] ref_beat;
        r         = rand32();
        last_r    = r_bursts;
        rd_off    = addr;
        exp_rid   = r[15:0];
        ref_beat  = ref_read(addr);
        exp_beats = (ref_beat[129:128] == 2'b10) ? 1 : int'(len) + 1;
        @(posedge clk);
        araddr  <= addr;
        arid    <= r[15:0];
        arlen   <= len;
        arvalid <= 1'b1;
        cnt = 0;
        do begin
            @(posedge clk);
            cnt++;
        end while (!arready && cnt < WAIT_LIMIT);
        if (cnt >= WAIT_LIMIT) report_timeout("arready");
        arvalid <= 1'b0;
        cnt = 0;
        while (r_bursts == last_r && cnt < WAIT_LIMIT) begin
            @(posedge clk);
            cnt++;
        end
        if (cnt >= WAIT_LIMIT) report_timeout("the last read beat");
    endtask

    task automatic finish_test(input string name);
        $display("Test %s finished with %0d errors", name, errors - test_errors);
        test_errors = errors;
    endtask

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////
    initial begin
        int cnt;
        int flush_exp;
        int flush_start;
        int img_start;
        int writes_start;
        logic [31:0] r;
        logic [127:0] w;

        seed = 32'h093c_7f67;
        rstn = 1'b0;
        awaddr = '0;
        awid = '0;
        awvalid = 1'b0;
        wdata = '0;
        wvalid = 1'b0;
        wlast = 1'b0;
        bready = 1'b1;
        araddr = '0;
        arid = '0;
        arlen = '0;
        arvalid = 1'b0;
        rready = 1'b1;
        fifo_full = 1'b0;
        dram_addr = '0;
        dram_len = '0;
        dram_en = 1'b0;
        exp_width = '0;
        exp_height = '0;
        exp_irq = 1'b0;
        exp_bresp = 2'b00;
        exp_bid = '0;
        rd_off = '0;
        exp_rid = '0;
        exp_beats = 1;
        b_count = 0;
        r_bursts = 0;
        r_beat_idx = 0;
        fifo_writes = 0;
        flush_pulses = 0;
        new_image_pulses = 0;
        checks = 0;
        errors = 0;
        test_errors = 0;
        held_valid = 1'b0;
        held_data = '0;
        full_random = 1'b0;
        rready_random = 1'b0;
        repeat (3) @(posedge clk);
        check_val("image_sender_reset", fifo_reset, 130'd1);
        rstn <= 1'b1;
        @(posedge clk);
        check_val("image_sender_reset", fifo_reset, 130'd0);
        finish_test("reset");

        // Pixel bursts under random back-pressure
        full_random = 1'b1;
        for (int b = 0; b < 5; b++) begin
            r = rand32();
            for (int i = 0; i <= int'(r[2:0]); i++) begin
                w = {rand32(), rand32(), rand32(), rand32()};
                beats_q.push_back(w);
                fifo_q.push_back(w);
            end
            write_burst(`REG_FIFO_DATA);
        end
        full_random = 1'b0;
        repeat (3) @(posedge clk);
        check_val("fifo words left", 130'(fifo_q.size()), 130'd0);
        finish_test("fifo_bursts");

        // Image size with wide fields truncated
        w = {rand32(), rand32(), rand32(), rand32()};
        exp_width  = w[43:32];
        exp_height = w[10:0];
        beats_q.push_back(w);
        write_burst(`REG_IMAGE_SIZE);
        check_val("image_width", width, exp_width);
        check_val("image_height", height, exp_height);
        read_burst(`REG_RESOLUTION, 8'd0);
        read_burst(`REG_RESOLUTION, 8'd2);
        finish_test("resolution");

        // Flush beats with mixed bit 0
        flush_exp   = 0;
        flush_start = flush_pulses;
        for (int i = 0; i < 6; i++) begin
            w = {rand32(), rand32(), rand32(), rand32()};
            if (w[0]) flush_exp++;
            beats_q.push_back(w);
        end
        write_burst(`REG_FLUSH);
        check_val("flush pulses", 130'(flush_pulses - flush_start), 130'(flush_exp));
        finish_test("flush");

        // Interrupt and new image
        @(posedge clk);
        dram_en <= 1'b1;
        @(posedge clk);
        dram_en <= 1'b0;
        cnt = 0;
        while (!irq && cnt < WAIT_LIMIT) begin
            @(posedge clk);
            cnt++;
        end
        if (cnt >= WAIT_LIMIT) report_timeout("irq_signal to rise");
        exp_irq = 1'b1;
        beats_q.push_back(128'd1);
        write_burst(`REG_DEASSERT_IRQ);
        exp_irq = 1'b0;
        check_val("irq_signal", irq, exp_irq);
        img_start = new_image_pulses;
        beats_q.push_back(128'd1);
        beats_q.push_back(128'd0);
        write_burst(`REG_SET_NEW_IMAGE);
        @(posedge clk);
        check_val("set_new_image pulses", 130'(new_image_pulses - img_start), 130'd1);
        finish_test("irq_new_image");

        // Unmapped offsets, with irq raised so a stray clear would show
        @(posedge clk);
        dram_en <= 1'b1;
        @(posedge clk);
        dram_en <= 1'b0;
        exp_irq = 1'b1;
        writes_start = fifo_writes;
        beats_q.push_back({rand32(), rand32(), rand32(), rand32()});
        beats_q.push_back({rand32(), rand32(), rand32(), rand32()});
        write_burst(7'h30);
        @(posedge clk);
        check_val("fifo writes", 130'(fifo_writes), 130'(writes_start));
        check_val("image_width", width, exp_width);
        check_val("image_height", height, exp_height);
        check_val("irq_signal", irq, exp_irq);
        read_burst(7'h40, 8'd3);
        finish_test("bad_address");

        // DRAM request with stalls
        r = rand32();
        dram_addr <= {r[6:0], rand32()};
        dram_len  <= r[15:8];
        @(posedge clk);
        rready_random = 1'b1;
        read_burst(`REG_DRAM_REQ, 8'd5);
        rready_random = 1'b0;
        finish_test("dram_request");

        repeat (3) @(posedge clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+src
src/axi2fifo_pkg.sv
src/wr_addr_decode.sv
src/wr_data_exec.sv
src/rd_engine.sv
src/axi2fifo_top.sv
bench/tb_axi2fifo.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator; the log decides the result
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f filelist.f --top-module tb_axi2fifo \
    -Mdir obj_dir -o sim_tb > build.log 2>&1 \
    || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1
grep -q "Everything OK" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
